// ==== rtl/div_pkg.sv ====
package div_pkg;

    // operand width is fixed by the instruction set
    localparam int data_width = 32;

    // destination register tag
    localparam int tag_width = 5;

    // leading-one position, 0 for zero up to 32
    localparam int pos_width = 6;

    // sequencer states
    typedef enum logic [1:0] {
        idle,
        prepare,
        calculate,
        finish
    } div_state_t;

    // which half of the division goes back to the pipeline
    typedef enum logic {
        op_quotient,
        op_remainder
    } div_op_t;

endpackage

// ==== rtl/exe_log2_plus_one.sv ====
`timescale 1ns/1ps

module exe_log2_plus_one (
    input  logic [div_pkg::data_width-1:0] value,
    output logic [div_pkg::pos_width-1:0]  pos
);
    import div_pkg::*;

    // highest set bit wins, scan runs from the bottom up
    always_comb begin
        pos = '0;
        for (int i = 0; i < data_width; i++) begin
            if (value[i]) begin
                pos = pos_width'(i + 1);
            end
        end
    end

endmodule

// ==== rtl/div_operand_prep.sv ====
`timescale 1ns/1ps

module div_operand_prep (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          capture,
    input  div_pkg::div_op_t              op,
    input  logic                          signed_mode,
    input  logic [div_pkg::data_width-1:0] dividend_in,
    input  logic [div_pkg::data_width-1:0] divisor_in,
    input  logic [div_pkg::tag_width-1:0]  tag_in,
    output logic [div_pkg::data_width-1:0] dividend_mag,
    output logic [div_pkg::data_width-1:0] divisor_mag,
    output logic                          skip,
    output logic [div_pkg::pos_width-1:0]  step_count,
    output logic [div_pkg::pos_width-1:0]  align_shift,
    output div_pkg::div_op_t              op_q,
    output logic                          dividend_neg,
    output logic                          divisor_neg,
    output logic [div_pkg::tag_width-1:0]  tag_q
);
    import div_pkg::*;

    logic                 dividend_sign;
    logic                 divisor_sign;
    logic [pos_width-1:0] dividend_pos;
    logic [pos_width-1:0] divisor_pos;
    logic [pos_width-1:0] dividend_pos_q;
    logic [pos_width-1:0] divisor_pos_q;

    // sign only counts in signed mode
    assign dividend_sign = signed_mode & dividend_in[data_width-1];
    assign divisor_sign  = signed_mode & divisor_in[data_width-1];

    // most negative value maps onto itself, read as unsigned it is correct
    assign dividend_mag = dividend_sign ? ~dividend_in + 1'b1 : dividend_in;
    assign divisor_mag  = divisor_sign ? ~divisor_in + 1'b1 : divisor_in;

    exe_log2_plus_one dividend_log2 (
        .value (dividend_mag),
        .pos   (dividend_pos)
    );

    exe_log2_plus_one divisor_log2 (
        .value (divisor_mag),
        .pos   (divisor_pos)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dividend_pos_q <= '0;
            divisor_pos_q  <= '0;
        end else if (capture) begin
            dividend_pos_q <= dividend_pos;
            divisor_pos_q  <= divisor_pos;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            op_q         <= op;
            tag_q        <= tag_in;
            dividend_neg <= dividend_sign;
            divisor_neg  <= divisor_sign;
        end
    end

    // zero divisor, or divisor wider than dividend: quotient is 0
    assign skip        = (divisor_pos_q == '0) || (dividend_pos_q < divisor_pos_q);
    assign step_count  = dividend_pos_q - divisor_pos_q;
    assign align_shift = step_count;

    // the loop never needs more than one step per quotient bit
    assert property (@(posedge clk) disable iff (reset)
        !skip |-> step_count < data_width);

endmodule

// ==== rtl/div_control_fsm.sv ====
`timescale 1ns/1ps

module div_control_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic skip,
    input  logic last,
    output logic capture,
    output logic load,
    output logic step_en,
    output logic finalize,
    output logic busy,
    output logic done
);
    import div_pkg::*;

    div_state_t state;
    div_state_t state_next;
    logic       steps_done;

    always_comb begin
        state_next = state;
        capture    = 1'b0;
        load       = 1'b0;
        step_en    = 1'b0;
        finalize   = 1'b0;
        case (state)
            idle: begin
                if (start) begin
                    capture    = 1'b1;
                    state_next = prepare;
                end
            end
            prepare: begin
                if (skip) begin
                    finalize   = 1'b1;
                    state_next = finish;
                end else begin
                    load       = 1'b1;
                    state_next = calculate;
                end
            end
            calculate: begin
                // one extra cycle after the last step to write the result
                if (steps_done) begin
                    finalize   = 1'b1;
                    state_next = finish;
                end else begin
                    step_en = 1'b1;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            busy       <= 1'b0;
            done       <= 1'b0;
            steps_done <= 1'b0;
        end else begin
            state <= state_next;
            done  <= (state == finish);
            if (capture) begin
                busy <= 1'b1;
            end else if (state == finish) begin
                busy <= 1'b0;
            end
            if (step_en && last) begin
                steps_done <= 1'b1;
            end else if (finalize) begin
                steps_done <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) done |=> !done);
    assert property (@(posedge clk) disable iff (reset) !(busy && done));
    // pipeline must stall while busy
    assert property (@(posedge clk) disable iff (reset) !(start && busy));

endmodule

// ==== rtl/div_step_counter.sv ====
`timescale 1ns/1ps

module div_step_counter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  logic                         step_en,
    input  logic [div_pkg::pos_width-1:0] step_count,
    output logic                         last
);
    import div_pkg::*;

    logic [pos_width-1:0] remaining;

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= step_count;
        end else if (step_en && remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // step taken with a zero count is the final one
    assign last = (remaining == '0);

    // no step past the final one until the next divide loads
    assert property (@(posedge clk) disable iff (reset)
        (step_en && last) |=> (!step_en until load));

endmodule

// ==== rtl/div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          capture,
    input  logic                          load,
    input  logic                          step_en,
    input  logic                          finalize,
    input  logic [div_pkg::data_width-1:0] dividend_mag,
    input  logic [div_pkg::data_width-1:0] divisor_mag,
    input  logic [div_pkg::pos_width-1:0]  align_shift,
    input  div_pkg::div_op_t              op_q,
    input  logic                          dividend_neg,
    input  logic                          divisor_neg,
    input  logic [div_pkg::tag_width-1:0]  tag_q,
    output logic [div_pkg::data_width-1:0] result,
    output logic [div_pkg::tag_width-1:0]  tag_out
);
    import div_pkg::*;

    logic [data_width-1:0] rem_q;
    logic [data_width-1:0] divisor_q;
    logic [data_width-1:0] quo_q;
    logic                  fits;
    logic [data_width-1:0] rem_signed;
    logic [data_width-1:0] quo_signed;

    assign fits = (divisor_q <= rem_q);

    always_ff @(posedge clk) begin
        if (capture) begin
            rem_q     <= dividend_mag;
            divisor_q <= divisor_mag;
            quo_q     <= '0;
        end else if (load) begin
            // line the divisor's top bit up with the dividend's
            divisor_q <= divisor_q << align_shift;
        end else if (step_en) begin
            if (fits) begin
                rem_q <= rem_q - divisor_q;
            end
            quo_q     <= {quo_q[data_width-2:0], fits};
            divisor_q <= divisor_q >> 1;
        end
    end

    // remainder follows the dividend, quotient follows the sign difference
    always_comb begin
        rem_signed = dividend_neg ? ~rem_q + 1'b1 : rem_q;
        quo_signed = (dividend_neg ^ divisor_neg) ? ~quo_q + 1'b1 : quo_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result  <= '0;
            tag_out <= '0;
        end else if (finalize) begin
            result  <= (op_q == op_remainder) ? rem_signed : quo_signed;
            tag_out <= tag_q;
        end
    end

endmodule

// ==== rtl/div_unit.sv ====
`timescale 1ns/1ps

module div_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  div_pkg::div_op_t              op,
    input  logic                          signed_mode,
    input  logic [div_pkg::data_width-1:0] dividend_in,
    input  logic [div_pkg::data_width-1:0] divisor_in,
    input  logic [div_pkg::tag_width-1:0]  tag_in,
    output logic                          busy,
    output logic                          done,
    output logic [div_pkg::data_width-1:0] result,
    output logic [div_pkg::tag_width-1:0]  tag_out
);
    import div_pkg::*;

    logic [data_width-1:0] dividend_mag;
    logic [data_width-1:0] divisor_mag;
    logic                  skip;
    logic [pos_width-1:0]  step_count;
    logic [pos_width-1:0]  align_shift;
    div_op_t               op_q;
    logic                  dividend_neg;
    logic                  divisor_neg;
    logic [tag_width-1:0]  tag_q;
    logic                  capture;
    logic                  load;
    logic                  step_en;
    logic                  finalize;
    logic                  last;

    div_operand_prep prep0 (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .op           (op),
        .signed_mode  (signed_mode),
        .dividend_in  (dividend_in),
        .divisor_in   (divisor_in),
        .tag_in       (tag_in),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .skip         (skip),
        .step_count   (step_count),
        .align_shift  (align_shift),
        .op_q         (op_q),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .tag_q        (tag_q)
    );

    div_control_fsm fsm0 (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .skip     (skip),
        .last     (last),
        .capture  (capture),
        .load     (load),
        .step_en  (step_en),
        .finalize (finalize),
        .busy     (busy),
        .done     (done)
    );

    div_step_counter counter0 (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .step_en    (step_en),
        .step_count (step_count),
        .last       (last)
    );

    div_datapath datapath0 (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .load         (load),
        .step_en      (step_en),
        .finalize     (finalize),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .align_shift  (align_shift),
        .op_q         (op_q),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .tag_q        (tag_q),
        .result       (result),
        .tag_out      (tag_out)
    );

endmodule

// ==== sim/div_clock_gen.sv ====
`timescale 1ns/1ps

module div_clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for the first five rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== sim/div_unit_tb.sv ====
`timescale 1ns/1ps

module div_unit_tb;
    import div_pkg::*;

    localparam int num_directed = 28;
    localparam int num_random   = 60;
    localparam int cycle_limit  = 40 * (num_directed + num_random) + 5 + 10;

    logic                  clk;
    logic                  reset;
    logic                  start;
    div_op_t               op;
    logic                  signed_mode;
    logic [data_width-1:0] dividend_in;
    logic [data_width-1:0] divisor_in;
    logic [tag_width-1:0]  tag_in;
    logic                  busy;
    logic                  done;
    logic [data_width-1:0] result;
    logic [tag_width-1:0]  tag_out;

    logic [data_width-1:0] exp_result;
    logic [tag_width-1:0]  exp_tag;
    logic [tag_width-1:0]  next_tag;
    int                    exp_cycles = 0;
    int                    op_cycles = 0;
    int                    cycle_count = 0;
    int                    seed;

    div_clock_gen clock0 (
        .clk   (clk),
        .reset (reset)
    );

    div_unit dut0 (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op),
        .signed_mode (signed_mode),
        .dividend_in (dividend_in),
        .divisor_in  (divisor_in),
        .tag_in      (tag_in),
        .busy        (busy),
        .done        (done),
        .result      (result),
        .tag_out     (tag_out)
    );

    task automatic stop_on_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    function automatic int top_bit_pos(input logic [data_width-1:0] v);
        for (int i = data_width - 1; i >= 0; i--) begin
            if (v[i]) begin
                return i + 1;
            end
        end
        return 0;
    endfunction

    // reference model on magnitudes with a sign fix-up
    function automatic logic [data_width-1:0] model_result(input div_op_t div_op,
            input logic is_signed, input logic [data_width-1:0] a,
            input logic [data_width-1:0] b);
        logic                  a_neg;
        logic                  b_neg;
        logic [data_width-1:0] a_mag;
        logic [data_width-1:0] b_mag;
        logic [data_width-1:0] q;
        logic [data_width-1:0] r;
        a_neg = is_signed && a[data_width-1];
        b_neg = is_signed && b[data_width-1];
        a_mag = a_neg ? -a : a;
        b_mag = b_neg ? -b : b;
        if (b == '0) begin
            q = '0;
            r = a;
        end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = 32'h8000_0000;
            r = '0;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
            if (a_neg != b_neg) q = -q;
            if (a_neg) r = -r;
        end
        return (div_op == op_remainder) ? r : q;
    endfunction

    // cycles from the sampled start to done
    function automatic int expected_latency(input logic is_signed,
            input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        int a_pos;
        int b_pos;
        a_pos = top_bit_pos((is_signed && a[data_width-1]) ? -a : a);
        b_pos = top_bit_pos((is_signed && b[data_width-1]) ? -b : b);
        if (b_pos == 0 || b_pos > a_pos) return 3;
        return a_pos - b_pos + 5;
    endfunction

    task automatic run_divide(input div_op_t div_op, input logic is_signed,
            input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        @(posedge clk);
        start       <= 1'b1;
        op          <= div_op;
        signed_mode <= is_signed;
        dividend_in <= a;
        divisor_in  <= b;
        tag_in      <= next_tag;
        exp_tag     <= next_tag;
        exp_result  <= model_result(div_op, is_signed, a, b);
        exp_cycles  <= expected_latency(is_signed, a, b);
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // inputs are don't-care once captured
        op          <= (div_op == op_quotient) ? op_remainder : op_quotient;
        signed_mode <= ~is_signed;
        dividend_in <= $random(seed);
        divisor_in  <= $random(seed);
        tag_in      <= ~tag_in;
        while (!done) begin
            @(posedge clk);
        end
    endtask

    task automatic run_both(input logic is_signed, input logic [data_width-1:0] a,
            input logic [data_width-1:0] b);
        run_divide(op_quotient, is_signed, a, b);
        run_divide(op_remainder, is_signed, a, b);
    endtask

    task automatic random_divide(input logic is_signed);
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        div_op_t               rand_op;
        a       = $random(seed);
        a       = a >> ($random(seed) & 15);
        // narrow divisors give long loops and wide ones exit early
        b       = $random(seed);
        b       = b >> ($random(seed) & 31);
        rand_op = div_op_t'($random(seed) & 1);
        run_divide(rand_op, is_signed, a, b);
    endtask

    always @(posedge clk) begin
        if (start) begin
            op_cycles <= 1;
        end else begin
            op_cycles <= op_cycles + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    assert property (@(posedge clk) $past(reset) |->
        !busy && !done && result == '0 && tag_out == '0)
        else stop_on_error("outputs not cleared by reset");
    assert property (@(posedge clk) disable iff (reset) done |-> result == exp_result)
        else stop_on_error($sformatf("result %h, expected %h", result, exp_result));
    assert property (@(posedge clk) disable iff (reset) done |-> tag_out == exp_tag)
        else stop_on_error($sformatf("tag %0d, expected %0d", tag_out, exp_tag));
    assert property (@(posedge clk) disable iff (reset) done |-> op_cycles == exp_cycles)
        else stop_on_error($sformatf("done after %0d cycles, expected %0d",
            $sampled(op_cycles), exp_cycles));
    assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else stop_on_error("start issued while busy");
    assert property (@(posedge clk) disable iff (reset) start |=> busy)
        else stop_on_error("busy not raised after start");
    assert property (@(posedge clk) disable iff (reset) busy |=> busy || done)
        else stop_on_error("busy dropped before done");
    assert property (@(posedge clk) disable iff (reset) done |-> !busy)
        else stop_on_error("busy and done high together");
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else stop_on_error("done longer than one cycle");
    assert property (@(posedge clk) disable iff (reset) busy |-> op_cycles < 37)
        else stop_on_error("no done within 37 cycles of start");

    initial begin
        seed        = 32'ha6e4_6bfb;
        next_tag    = '0;
        start       = 1'b0;
        op          = op_quotient;
        signed_mode = 1'b0;
        dividend_in = '0;
        divisor_in  = '0;
        tag_in      = '0;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        run_both(1'b0, 32'd100, 32'd7);
        run_both(1'b0, 32'hffff_ffff, 32'd1);
        run_both(1'b0, 32'hffff_ffff, 32'hffff_ffff);
        run_both(1'b0, 32'd5, 32'd7);
        // early exits
        run_both(1'b0, 32'h1234_5678, 32'd0);
        run_both(1'b0, 32'd3, 32'h0001_0000);
        run_both(1'b0, 32'd0, 32'd5);
        run_both(1'b1, 32'd100, 32'd7);
        run_both(1'b1, -32'd100, 32'd7);
        run_both(1'b1, 32'd100, -32'd7);
        run_both(1'b1, -32'd100, -32'd7);
        run_both(1'b1, 32'h8000_0000, 32'hffff_ffff);
        run_both(1'b1, -32'd7, 32'd0);
        run_both(1'b1, -32'd3, 32'd100);
        for (int i = 0; i < num_random; i++) begin
            random_divide(i[0]);
        end
        repeat (3) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/div_pkg.sv
rtl/exe_log2_plus_one.sv
rtl/div_operand_prep.sv
rtl/div_control_fsm.sv
rtl/div_step_counter.sv
rtl/div_datapath.sv
rtl/div_unit.sv
sim/div_clock_gen.sv
sim/div_unit_tb.sv
